/* all.f */
+incdir+logic
logic/uart_cfg_pkg.sv
logic/rx_pkt_if.sv
logic/tx_req_if.sv
logic/rx_packet_decoder.sv
logic/cfg_slave_fsm.sv
logic/ack_sender.sv
logic/uart_cfg_ctrl.sv
tb/tb_uart_cfg_ctrl.sv

/* tb/tb_uart_cfg_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none
`include "uart_cfg_defines.svh"

module tb_uart_cfg_ctrl;

    import uart_cfg_pkg::*;

    // Cycle budget per test where one acknowledge round trip fits in ACK_CYC
    localparam int ACK_CYC     = 20;
    localparam int ROUNDS      = 4;
    localparam int BYTES       = 12;
    localparam int SESSION_CYC = 8 + 5 * ACK_CYC + 10;
    localparam int IGNORE_CYC  = 2 * ACK_CYC + 4 * 7;
    localparam int TIMEOUT_CYC = ACK_CYC + `CFG_TIMEOUT_CYCLES + 10;
    localparam int PARITY_CYC  = ROUNDS * (5 * ACK_CYC + 4 * BYTES);
    localparam int TOTAL_CYC   = 4 + SESSION_CYC + IGNORE_CYC + TIMEOUT_CYC + PARITY_CYC
                                 + SESSION_CYC;

    logic       clk_i = 1'b0;
    logic       rst_n_i;
    logic       rx_valid_i;
    logic [7:0] rx_data_i;
    logic       rx_parity_i;
    logic       rx_ready_o;
    logic       tx_valid_o;
    logic [7:0] tx_data_o;
    logic       tx_ready_i;
    logic       tx_done_i;
    logic       config_req_slv_i;
    logic       enable_config_receive_i;
    logic       set_std_config_i;
    logic [1:0] data_width_o;
    logic [1:0] parity_mode_o;
    logic [1:0] stop_bits_o;
    logic       config_done_o;
    logic       config_error_o;
    logic       parity_error_o;

    integer       seed = 32'h23e9_11ee;
    int           errors = 0;
    int           checks = 0;
    int           tests = 0;
    int           failed = 0;
    int           test_err;
    int           pulses;
    int           cyc;
    logic [7:0]   byte_val;
    logic         par;
    logic         exp_err;
    // Model of the configuration register
    uart_config_s exp_cfg;

    uart_cfg_ctrl i_dut (.*);

    always #2 clk_i = ~clk_i;

    // Watchdog allows twice the summed budget of all tests
    initial begin
        #(TOTAL_CYC * 4 * 2);
        $display("timeout: the run did not finish within %0d cycles", 2 * TOTAL_CYC);
        $display("CHECKS FAILED");
        $finish;
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    function automatic int rand_below(input int n);
        rand_below = $unsigned($random(seed)) % n;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("error at %0t ns: %s", $time, what);
    endtask

    task automatic start_test;
        tests++;
        test_err = errors;
    endtask

    task automatic end_test(input string name);
        if (errors == test_err) begin
            $display("test %-12s passed", name);
        end else begin
            failed++;
            $display("test %-12s failed with %0d errors", name, errors - test_err);
        end
    endtask

    task automatic check_cfg;
        check("data_width_o", data_width_o, exp_cfg.data_width);
        check("parity_mode_o", parity_mode_o, exp_cfg.parity_mode);
        check("stop_bits_o", stop_bits_o, exp_cfg.stop_bits);
    endtask

    // Parity is the XOR of the low 5 to 8 data bits, flipped for odd and off for NONE modes
    function automatic logic parity_bad(input logic [7:0] data, input logic bit_in);
        logic [7:0] mask;
        logic       calc;
        mask = 8'hff >> (3 - exp_cfg.data_width);
        calc = ^(data & mask);
        if (exp_cfg.parity_mode == ODD) begin
            calc = !calc;
        end
        parity_bad = (exp_cfg.parity_mode == EVEN || exp_cfg.parity_mode == ODD)
                     && (calc != bit_in);
    endfunction

    // Transmitter stub with random ready and done delays
    task automatic serve_ack;
        int wait_cyc;
        wait_cyc = 0;
        while (!tx_valid_o && wait_cyc < 10) begin
            @(negedge clk_i);
            wait_cyc++;
        end
        if (!tx_valid_o) begin
            report_failure("no acknowledge byte was offered to the transmitter");
        end else begin
            check("tx_data_o", tx_data_o, `ACKN_BYTE);
            repeat (rand_below(4)) begin
                @(negedge clk_i);
                check("tx_valid_o", tx_valid_o, 1'b1);
            end
            tx_ready_i = 1'b1;
            @(negedge clk_i);
            tx_ready_i = 1'b0;
            repeat (rand_below(4)) @(negedge clk_i);
            tx_done_i = 1'b1;
            @(negedge clk_i);
            tx_done_i = 1'b0;
        end
    endtask

    // Returns on the falling edge right after the byte was taken
    task automatic send_byte(input logic [7:0] data, input logic bit_in);
        int wait_cyc;
        wait_cyc = 0;
        rx_valid_i  = 1'b1;
        rx_data_i   = data;
        rx_parity_i = bit_in;
        while (!rx_ready_o && wait_cyc < 100) begin
            @(negedge clk_i);
            wait_cyc++;
        end
        if (!rx_ready_o) begin
            report_failure("the receive side never became ready");
        end
        @(negedge clk_i);
        rx_valid_i = 1'b0;
    endtask

    task automatic send_pkt(input logic [1:0] id, input logic [1:0] opt);
        send_byte({`CFG_PKT_TAG, id, opt}, 1'b0);
        case (cfg_id_e'(id))
            DATA_WIDTH_ID:  exp_cfg.data_width  = data_width_e'(opt);
            PARITY_MODE_ID: exp_cfg.parity_mode = parity_mode_e'(opt);
            STOP_BITS_ID:   exp_cfg.stop_bits   = stop_bits_e'(opt);
            default:        ;
        endcase
        serve_ack();
    endtask

    task automatic wait_config_done;
        int wait_cyc;
        wait_cyc = 0;
        while (!config_done_o && wait_cyc < 10) begin
            @(negedge clk_i);
            wait_cyc++;
        end
        if (!config_done_o) begin
            report_failure("config_done_o did not return high after the session");
        end
    endtask

    task automatic open_session;
        enable_config_receive_i = 1'b1;
        config_req_slv_i        = 1'b1;
        @(negedge clk_i);
        config_req_slv_i = 1'b0;
        serve_ack();
    endtask

    task automatic custom_session(input logic [1:0] dw, input logic [1:0] pm,
                                  input logic [1:0] sb);
        open_session();
        send_pkt(DATA_WIDTH_ID, dw);
        send_pkt(PARITY_MODE_ID, pm);
        send_pkt(STOP_BITS_ID, sb);
        send_pkt(END_CONFIG_ID, rand_below(4));
        wait_config_done();
        check_cfg();
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------

    initial begin
        rst_n_i                 = 1'b0;
        rx_valid_i              = 1'b0;
        rx_data_i               = 8'h00;
        rx_parity_i             = 1'b0;
        tx_ready_i              = 1'b0;
        tx_done_i               = 1'b0;
        config_req_slv_i        = 1'b0;
        enable_config_receive_i = 1'b0;
        set_std_config_i        = 1'b0;
        exp_cfg                 = STD_CONFIGURATION;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        start_test();
        check_cfg();
        check("config_done_o", config_done_o, 1'b1);
        check("tx_valid_o", tx_valid_o, 1'b0);
        check("config_error_o", config_error_o, 1'b0);
        check("parity_error_o", parity_error_o, 1'b0);
        check("rx_ready_o", rx_ready_o, 1'b1);
        end_test("reset");

        // A request with receive disabled must stay unanswered
        start_test();
        config_req_slv_i = 1'b1;
        @(negedge clk_i);
        config_req_slv_i = 1'b0;
        repeat (6) begin
            @(negedge clk_i);
            check("tx_valid_o", tx_valid_o, 1'b0);
        end
        check("config_done_o", config_done_o, 1'b1);
        custom_session(rand_below(4), rand_below(4), rand_below(4));
        end_test("session");

        // A byte that arrives while the acknowledge is pending fills the decoder and waits
        start_test();
        enable_config_receive_i = 1'b1;
        config_req_slv_i        = 1'b1;
        @(negedge clk_i);
        config_req_slv_i = 1'b0;
        send_byte(8'h5a, 1'b0);
        check("rx_ready_o", rx_ready_o, 1'b0);
        serve_ack();
        repeat (4) begin
            byte_val = rand_below(256);
            // Break the tag so the byte cannot count as a packet
            if (byte_val[7:4] == `CFG_PKT_TAG) begin
                byte_val[7] = ~byte_val[7];
            end
            send_byte(byte_val, rand_below(2));
            repeat (3) begin
                @(negedge clk_i);
                check("tx_valid_o", tx_valid_o, 1'b0);
            end
        end
        check_cfg();
        send_pkt(END_CONFIG_ID, rand_below(4));
        wait_config_done();
        check_cfg();
        end_test("ignored");

        // Open a session and then stay silent past the timeout
        start_test();
        open_session();
        exp_cfg = STD_CONFIGURATION;
        pulses  = 0;
        cyc     = 0;
        while (!config_done_o && cyc < `CFG_TIMEOUT_CYCLES + 10) begin
            @(negedge clk_i);
            pulses += config_error_o;
            cyc++;
        end
        check("timeout reached after the full wait", cyc >= `CFG_TIMEOUT_CYCLES, 1'b1);
        repeat (3) begin
            @(negedge clk_i);
            pulses += config_error_o;
        end
        check("config_error_o pulses", pulses, 1);
        check("config_done_o", config_done_o, 1'b1);
        check_cfg();
        end_test("timeout");

        // The last round forces NONE, where no error may ever show
        start_test();
        for (int round = 0; round < ROUNDS; round++) begin
            custom_session(rand_below(4), (round == ROUNDS - 1) ? NONE : rand_below(4),
                           rand_below(4));
            repeat (BYTES) begin
                byte_val = rand_below(256);
                par      = rand_below(2);
                exp_err  = parity_bad(byte_val, par);
                send_byte(byte_val, par);
                check("parity_error_o", parity_error_o, 1'b0);
                @(negedge clk_i);
                check("parity_error_o", parity_error_o, exp_err);
                @(negedge clk_i);
                check("parity_error_o", parity_error_o, 1'b0);
            end
        end
        end_test("parity");

        start_test();
        custom_session(rand_below(4), EVEN, SB_2BIT);
        set_std_config_i = 1'b1;
        @(negedge clk_i);
        set_std_config_i = 1'b0;
        exp_cfg          = STD_CONFIGURATION;
        wait_config_done();
        check_cfg();
        end_test("std restore");

        $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
                 tests, failed, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule : tb_uart_cfg_ctrl

`default_nettype wire

/* logic/uart_cfg_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_cfg_ctrl (
    input  logic       clk_i,
    input  logic       rst_n_i,
    // Receive side
    input  logic       rx_valid_i,
    input  logic [7:0] rx_data_i,
    input  logic       rx_parity_i,
    output logic       rx_ready_o,
    // Transmit side
    output logic       tx_valid_o,
    output logic [7:0] tx_data_o,
    input  logic       tx_ready_i,
    input  logic       tx_done_i,
    // Host control
    input  logic       config_req_slv_i,
    input  logic       enable_config_receive_i,
    input  logic       set_std_config_i,
    // Status and active configuration
    output logic [1:0] data_width_o,
    output logic [1:0] parity_mode_o,
    output logic [1:0] stop_bits_o,
    output logic       config_done_o,
    output logic       config_error_o,
    output logic       parity_error_o
);

    import uart_cfg_pkg::*;

    uart_config_s cfg;

    rx_pkt_if u_rx_pkt ();
    tx_req_if u_tx_req ();

    // Parity is checked against the configuration the FSM holds
    rx_packet_decoder i_decoder (
        .clk_i, .rst_n_i, .rx_valid_i, .rx_parity_i, .rx_data_i, .rx_ready_o,
        .cfg_i (cfg), .parity_error_o, .pkt (u_rx_pkt.decoder)
    );

    cfg_slave_fsm i_fsm (
        .clk_i, .rst_n_i, .config_req_slv_i, .enable_config_receive_i, .set_std_config_i,
        .cfg_o (cfg), .config_done_o, .config_error_o,
        .pkt (u_rx_pkt.fsm), .ack (u_tx_req.fsm)
    );

    ack_sender i_sender (
        .clk_i, .rst_n_i, .tx_ready_i, .tx_done_i, .tx_valid_o, .tx_data_o,
        .ack (u_tx_req.sender)
    );

    assign data_width_o  = cfg.data_width;
    assign parity_mode_o = cfg.parity_mode;
    assign stop_bits_o   = cfg.stop_bits;

endmodule : uart_cfg_ctrl

`default_nettype wire

/* logic/ack_sender.sv */
`timescale 1ns/10ps
`default_nettype none
`include "uart_cfg_defines.svh"

module ack_sender (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       tx_ready_i,
    input  logic       tx_done_i,
    output logic       tx_valid_o,
    output logic [7:0] tx_data_o,
    tx_req_if.sender   ack
);

    // Idle, byte offered to the transmitter, frame on the line
    typedef enum logic [1:0] {SND_IDLE, SND_PRESENT, SND_WAIT_DONE} snd_state_e;

    snd_state_e state_q;

    // Only one byte is ever sent, so the data never changes
    assign tx_data_o  = `ACKN_BYTE;
    assign tx_valid_o = state_q == SND_PRESENT;
    assign ack.busy   = state_q != SND_IDLE;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q  <= SND_IDLE;
            ack.done <= 1'b0;
        end else begin
            ack.done <= 1'b0;
            case (state_q)
                SND_IDLE:      if (ack.req) state_q <= SND_PRESENT;
                // Hold valid until the transmitter takes the byte
                SND_PRESENT:   if (tx_ready_i) state_q <= SND_WAIT_DONE;
                SND_WAIT_DONE: begin
                    if (tx_done_i) begin
                        state_q  <= SND_IDLE;
                        ack.done <= 1'b1;
                    end
                end
                default:       state_q <= SND_IDLE;
            endcase
        end
    end

endmodule : ack_sender

`default_nettype wire

/* logic/cfg_slave_fsm.sv */
`timescale 1ns/10ps
`default_nettype none
`include "uart_cfg_defines.svh"

module cfg_slave_fsm (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       config_req_slv_i,
    input  logic                       enable_config_receive_i,
    input  logic                       set_std_config_i,
    output uart_cfg_pkg::uart_config_s cfg_o,
    output logic                       config_done_o,
    output logic                       config_error_o,
    rx_pkt_if.fsm                      pkt,
    tx_req_if.fsm                      ack
);

    import uart_cfg_pkg::*;

    cfg_state_e       state_q;
    cfg_state_e       state_d;
    logic [`CNT_W-1:0] cnt_q;
    logic             end_seen_q;
    logic             timeout;
    logic             pkt_take;

    // Timer only runs while waiting for a packet in setup
    assign timeout       = cnt_q == `CNT_W'(`CFG_TIMEOUT_CYCLES);
    assign config_done_o = state_q == MAIN;

    // ------------------------------
    // Next state and handshakes
    // ------------------------------

    always_comb begin
        state_d   = state_q;
        pkt.ready = 1'b0;
        ack.req   = 1'b0;
        pkt_take  = 1'b0;
        case (state_q)
            MAIN: begin
                // Normal operation drops every received byte
                pkt.ready = 1'b1;
                if (config_req_slv_i && enable_config_receive_i) begin
                    state_d = SEND_ACKN;
                end else if (set_std_config_i) begin
                    state_d = STD_CONFIG;
                end
            end
            STD_CONFIG: state_d = MAIN;
            SEND_ACKN: begin
                if (!ack.busy) begin
                    ack.req = 1'b1;
                    state_d = WAIT_TX;
                end
            end
            // No timeout here, a slow transmitter just stretches the session
            WAIT_TX: begin
                if (ack.done) begin
                    state_d = end_seen_q ? MAIN : SETUP_SLV;
                end
            end
            SETUP_SLV: begin
                if (timeout) begin
                    state_d = STD_CONFIG;
                end else begin
                    pkt.ready = 1'b1;
                    // Untagged bytes are consumed and the timer keeps going
                    if (pkt.valid && pkt.is_cfg) begin
                        pkt_take = 1'b1;
                        state_d  = SEND_ACKN;
                    end
                end
            end
            default: state_d = MAIN;
        endcase
    end

    // ------------------------------
    // State, timer and config register
    // ------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q        <= MAIN;
            cfg_o          <= STD_CONFIGURATION;
            cnt_q          <= '0;
            end_seen_q     <= 1'b0;
            config_error_o <= 1'b0;
        end else begin
            state_q        <= state_d;
            config_error_o <= (state_q == SETUP_SLV) && timeout;
            // Leaving setup for an acknowledge restarts the timer
            cnt_q <= (state_q == SETUP_SLV) ? cnt_q + 1'b1 : '0;
            if (state_q == MAIN) begin
                end_seen_q <= 1'b0;
            end
            if (state_q == STD_CONFIG) begin
                cfg_o <= STD_CONFIGURATION;
            end
            if (pkt_take) begin
                case (pkt.id)
                    DATA_WIDTH_ID:  cfg_o.data_width  <= data_width_e'(pkt.option);
                    PARITY_MODE_ID: cfg_o.parity_mode <= parity_mode_e'(pkt.option);
                    STOP_BITS_ID:   cfg_o.stop_bits   <= stop_bits_e'(pkt.option);
                    default:        end_seen_q        <= 1'b1;
                endcase
            end
        end
    end

endmodule : cfg_slave_fsm

`default_nettype wire

/* logic/rx_packet_decoder.sv */
`timescale 1ns/10ps
`default_nettype none
`include "uart_cfg_defines.svh"

module rx_packet_decoder (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       rx_valid_i,
    input  logic                       rx_parity_i,
    input  logic [7:0]                 rx_data_i,
    output logic                       rx_ready_o,
    input  uart_cfg_pkg::uart_config_s cfg_i,
    output logic                       parity_error_o,
    rx_pkt_if.decoder                  pkt
);

    import uart_cfg_pkg::*;

    logic accept;
    logic calc_parity;
    logic mismatch;

    // Room in the register when it is empty or drained this cycle
    assign rx_ready_o = !pkt.valid || pkt.ready;
    assign accept     = rx_valid_i && rx_ready_o;

    // ------------------------------
    // Parity check at acceptance
    // ------------------------------

    always_comb begin
        // XOR only the bits that belong to the active data width
        case (cfg_i.data_width)
            DW_5BIT: calc_parity = ^rx_data_i[4:0];
            DW_6BIT: calc_parity = ^rx_data_i[5:0];
            DW_7BIT: calc_parity = ^rx_data_i[6:0];
            default: calc_parity = ^rx_data_i;
        endcase
        // Odd parity is the even result flipped
        case (cfg_i.parity_mode)
            EVEN:    mismatch = rx_parity_i != calc_parity;
            ODD:     mismatch = rx_parity_i != !calc_parity;
            default: mismatch = 1'b0;
        endcase
    end

    // ------------------------------
    // Output register
    // ------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pkt.valid      <= 1'b0;
            parity_error_o <= 1'b0;
        end else begin
            if (accept) begin
                pkt.valid <= 1'b1;
            end else if (pkt.ready) begin
                pkt.valid <= 1'b0;
            end
            // The error pulse lines up with the byte showing up on the interface
            parity_error_o <= accept && mismatch;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            pkt.data_byte <= rx_data_i;
        end
    end

    // Field split of the stored byte
    assign pkt.is_cfg = pkt.data_byte[`PKT_TAG_HI:`PKT_TAG_LO] == `CFG_PKT_TAG;
    assign pkt.id     = cfg_id_e'(pkt.data_byte[`PKT_ID_HI:`PKT_ID_LO]);
    assign pkt.option = pkt.data_byte[`PKT_OPT_HI:`PKT_OPT_LO];

endmodule : rx_packet_decoder

`default_nettype wire

/* logic/tx_req_if.sv */
`timescale 1ns/10ps
`default_nettype none

// Acknowledge request path from the FSM to the transmit side
interface tx_req_if;

    // Single-cycle request, only issued while busy is low
    logic req;
    // High from the cycle after req until the frame is done
    logic busy;
    // One-cycle pulse after the transmitter has finished
    logic done;

    modport fsm (
        output req,
        input  busy, done
    );

    modport sender (
        input  req,
        output busy, done
    );

endinterface : tx_req_if

`default_nettype wire

/* logic/rx_pkt_if.sv */
`timescale 1ns/10ps
`default_nettype none

// One received byte, already split into its packet fields
interface rx_pkt_if;

    import uart_cfg_pkg::*;

    logic       valid;
    logic [7:0] data_byte;
    logic       is_cfg;
    cfg_id_e    id;
    logic [1:0] option;
    // Transfer happens when valid and ready are both high
    logic       ready;

    // The decoder reads back its own register to derive the fields
    modport decoder (
        output valid, data_byte, is_cfg, id, option,
        input  ready
    );

    modport fsm (
        input  valid, data_byte, is_cfg, id, option,
        output ready
    );

endinterface : rx_pkt_if

`default_nettype wire

/* logic/uart_cfg_pkg.sv */
`default_nettype none

package uart_cfg_pkg;

    // Slave configuration FSM states
    typedef enum logic [2:0] {
        MAIN,
        STD_CONFIG,
        SEND_ACKN,
        WAIT_TX,
        SETUP_SLV
    } cfg_state_e;

    // Packet ID, tells which field the option belongs to
    typedef enum logic [1:0] {
        DATA_WIDTH_ID,
        PARITY_MODE_ID,
        STOP_BITS_ID,
        END_CONFIG_ID
    } cfg_id_e;

    typedef enum logic [1:0] {DW_5BIT, DW_6BIT, DW_7BIT, DW_8BIT} data_width_e;

    // NONE and NONE2 both switch the parity check off
    typedef enum logic [1:0] {EVEN, ODD, NONE, NONE2} parity_mode_e;

    typedef enum logic [1:0] {SB_1BIT, SB_2BIT, SB_RSVD_A, SB_RSVD_B} stop_bits_e;

    // Active line configuration, 6 bits in total
    typedef struct packed {
        data_width_e  data_width;
        parity_mode_e parity_mode;
        stop_bits_e   stop_bits;
    } uart_config_s;

    // Fallback setting: 8 data bits, no parity, one stop bit
    localparam uart_config_s STD_CONFIGURATION = '{
        data_width:  DW_8BIT,
        parity_mode: NONE,
        stop_bits:   SB_1BIT
    };

endpackage : uart_cfg_pkg

`default_nettype wire

/* logic/uart_cfg_defines.svh */
`ifndef UART_CFG_DEFINES_SVH
`define UART_CFG_DEFINES_SVH

// Upper nibble that marks a byte as a configuration packet
`define CFG_PKT_TAG 4'hC

// Byte sent back for a request and for every configuration packet
`define ACKN_BYTE 8'h06

// Cycles the slave waits in setup for the next packet
`define CFG_TIMEOUT_CYCLES 64

// Wide enough to hold the timeout value itself
`define CNT_W 7

// Configuration packet layout: tag, packet ID, option
`define PKT_TAG_HI 7
`define PKT_TAG_LO 4
`define PKT_ID_HI 3
`define PKT_ID_LO 2
`define PKT_OPT_HI 1
`define PKT_OPT_LO 0

`endif
